/* verilog/fabric_mem_cfg_pkg.sv */
// ----------------------------------------------------------------------
// Scratchpad configuration
// Fixed sizes, port counts and the stream payload type
// ----------------------------------------------------------------------

package fabric_mem_cfg_pkg;

  // Word and tag widths
  localparam int DATA_WIDTH    = 16;
  localparam int TAG_WIDTH     = 2;
  // Tag field sits directly above the data field
  localparam int PAYLOAD_WIDTH = DATA_WIDTH + TAG_WIDTH;

  // Port counts
  localparam int LD_COUNT = 2;
  localparam int ST_COUNT = 2;

  // Memory size
  localparam int MEM_DEPTH  = 16;
  localparam int ADDR_WIDTH = 4;

  // Store pairing timeout in cycles
  // Small enough for simulation to reach it
  localparam int DEADLOCK_TIMEOUT = 15;
  localparam int DL_CNT_WIDTH     = 4;

  // One stream payload {tag, data}
  typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

endpackage

/* verilog/fabric_err_pkg.sv */
// ----------------------------------------------------------------------
// Scratchpad runtime error codes
// ----------------------------------------------------------------------

package fabric_err_pkg;

  // Error code as seen on error_code
  typedef logic [15:0] err_code_t;

  // No error latched
  localparam err_code_t RT_MEMORY_NONE           = 16'd0;
  // Request tag not below the port count
  localparam err_code_t RT_MEMORY_TAG_OOB        = 16'd1;
  // Store half waited too long for its partner
  localparam err_code_t RT_MEMORY_STORE_DEADLOCK = 16'd2;

endpackage

/* verilog/mem_load_ports.sv */
// ----------------------------------------------------------------------
// Load port unit
// Load handshakes, tagged read data, merged load-done stream and
// out-of-range load tag detection
// ----------------------------------------------------------------------

module mem_load_ports
  import fabric_mem_cfg_pkg::*;
(
  // Load address input streams
  input  logic     [LD_COUNT-1:0]                 ld_addr_valid,
  output logic     [LD_COUNT-1:0]                 ld_addr_ready,
  input  payload_t [LD_COUNT-1:0]                 ld_addr,
  // Load data output streams
  output logic     [LD_COUNT-1:0]                 ld_data_valid,
  input  logic     [LD_COUNT-1:0]                 ld_data_ready,
  output payload_t [LD_COUNT-1:0]                 ld_data,
  // Shared load-done stream
  output logic                                    ld_done_valid,
  input  logic                                    ld_done_ready,
  output payload_t                                ld_done,
  // Read ports of the memory array
  output logic     [LD_COUNT-1:0][ADDR_WIDTH-1:0] rd_addr,
  input  logic     [LD_COUNT-1:0][DATA_WIDTH-1:0] rd_data,
  // Error flag
  output logic                                    ld_tag_oob
);

  // --------------------------------------------------------------------
  // Per-port load path
  // --------------------------------------------------------------------
  genvar gi;
  generate
    for (gi = 0; gi < LD_COUNT; gi++) begin : g_port
      // Address from the low bits of the payload
      assign rd_addr[gi] = ld_addr[gi][ADDR_WIDTH-1:0];

      // Fires only when both downstream streams can take it
      assign ld_addr_ready[gi] = ld_addr_valid[gi] & ld_data_ready[gi] & ld_done_ready;

      // Zero latency read
      assign ld_data_valid[gi] = ld_addr_valid[gi];

      // Request tag goes back above the word
      assign ld_data[gi] = {ld_addr[gi][DATA_WIDTH +: TAG_WIDTH], rd_data[gi]};
    end
  endgenerate

  // --------------------------------------------------------------------
  // Load-done merge
  // --------------------------------------------------------------------
  always_comb begin : lddone_merge
    ld_done_valid = 1'b0;
    ld_done       = '0;
    // Ascending scan so the highest valid port wins the tag
    for (int i = 0; i < LD_COUNT; i++) begin
      if (ld_addr_valid[i]) begin
        ld_done_valid                       = 1'b1;
        ld_done[DATA_WIDTH +: TAG_WIDTH]    = ld_addr[i][DATA_WIDTH +: TAG_WIDTH];
      end
    end
  end

  // --------------------------------------------------------------------
  // Load tag range check
  // --------------------------------------------------------------------
  always_comb begin : ld_tag_check
    ld_tag_oob = 1'b0;
    for (int i = 0; i < LD_COUNT; i++) begin
      // Tag must stay below the load port count
      if (ld_addr_valid[i] && (int'(ld_addr[i][DATA_WIDTH +: TAG_WIDTH]) >= LD_COUNT)) begin
        ld_tag_oob = 1'b1;
      end
    end
  end

endmodule

/* verilog/mem_store_pairing.sv */
// ----------------------------------------------------------------------
// Store pairing unit
// Joins address and data halves into writes, merges the store-done
// stream and watches for tag and pairing errors
// ----------------------------------------------------------------------

module mem_store_pairing
  import fabric_mem_cfg_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst_n,
  // Store address and data input streams
  input  logic     [ST_COUNT-1:0]                 st_addr_valid,
  output logic     [ST_COUNT-1:0]                 st_addr_ready,
  input  payload_t [ST_COUNT-1:0]                 st_addr,
  input  logic     [ST_COUNT-1:0]                 st_data_valid,
  output logic     [ST_COUNT-1:0]                 st_data_ready,
  input  payload_t [ST_COUNT-1:0]                 st_data,
  // Shared store-done stream
  output logic                                    st_done_valid,
  input  logic                                    st_done_ready,
  output payload_t                                st_done,
  // Write ports of the memory array
  output logic     [ST_COUNT-1:0]                 wr_en,
  output logic     [ST_COUNT-1:0][ADDR_WIDTH-1:0] wr_addr,
  output logic     [ST_COUNT-1:0][DATA_WIDTH-1:0] wr_data,
  // Error flags
  output logic                                    st_tag_oob,
  output logic                                    st_deadlock
);

  // Both halves present
  logic [ST_COUNT-1:0] pair_valid;
  // Pair accepted this cycle
  logic [ST_COUNT-1:0] st_fire;
  // Counter at its limit
  logic [ST_COUNT-1:0] dl_hit;

  // --------------------------------------------------------------------
  // Per-port pairing and deadlock watch
  // --------------------------------------------------------------------
  genvar gj;
  generate
    for (gj = 0; gj < ST_COUNT; gj++) begin : g_port
      logic                    half_alone;
      logic [DL_CNT_WIDTH-1:0] dl_cnt;

      assign pair_valid[gj] = st_addr_valid[gj] & st_data_valid[gj];
      assign st_fire[gj]    = pair_valid[gj] & st_done_ready;

      // Both halves are consumed together
      assign st_addr_ready[gj] = st_fire[gj];
      assign st_data_ready[gj] = st_fire[gj];

      // Write goes out on the firing cycle
      assign wr_en[gj]   = st_fire[gj];
      assign wr_addr[gj] = st_addr[gj][ADDR_WIDTH-1:0];
      assign wr_data[gj] = st_data[gj][DATA_WIDTH-1:0];

      // Exactly one half waiting
      assign half_alone = st_addr_valid[gj] ^ st_data_valid[gj];

      // Saturating wait counter, cleared once the half is no longer alone
      always_ff @(posedge clk or negedge rst_n) begin : dl_counter
        if (!rst_n) begin
          dl_cnt <= '0;
        end else if (!half_alone) begin
          dl_cnt <= '0;
        end else if (dl_cnt != DL_CNT_WIDTH'(DEADLOCK_TIMEOUT)) begin
          dl_cnt <= dl_cnt + 1'b1;
        end
      end

      assign dl_hit[gj] = (dl_cnt == DL_CNT_WIDTH'(DEADLOCK_TIMEOUT));
    end
  endgenerate

  assign st_deadlock = |dl_hit;

  // --------------------------------------------------------------------
  // Store-done merge
  // --------------------------------------------------------------------
  always_comb begin : stdone_merge
    st_done_valid = 1'b0;
    st_done       = '0;
    // Highest valid pair forwards its address tag
    for (int j = 0; j < ST_COUNT; j++) begin
      if (pair_valid[j]) begin
        st_done_valid                    = 1'b1;
        st_done[DATA_WIDTH +: TAG_WIDTH] = st_addr[j][DATA_WIDTH +: TAG_WIDTH];
      end
    end
  end

  // --------------------------------------------------------------------
  // Store tag range check
  // --------------------------------------------------------------------
  always_comb begin : st_tag_check
    st_tag_oob = 1'b0;
    for (int j = 0; j < ST_COUNT; j++) begin
      // Address half
      if (st_addr_valid[j] && (int'(st_addr[j][DATA_WIDTH +: TAG_WIDTH]) >= ST_COUNT)) begin
        st_tag_oob = 1'b1;
      end
      // Data half is checked as well
      if (st_data_valid[j] && (int'(st_data[j][DATA_WIDTH +: TAG_WIDTH]) >= ST_COUNT)) begin
        st_tag_oob = 1'b1;
      end
    end
  end

endmodule

/* verilog/scratchpad_core.sv */
// ----------------------------------------------------------------------
// Scratchpad core
// Memory array with combinational reads, ordered writes and the
// sticky runtime error latch
// ----------------------------------------------------------------------

module scratchpad_core
  import fabric_mem_cfg_pkg::*, fabric_err_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  // Read ports
  input  logic [LD_COUNT-1:0][ADDR_WIDTH-1:0] rd_addr,
  output logic [LD_COUNT-1:0][DATA_WIDTH-1:0] rd_data,
  // Write ports
  input  logic [ST_COUNT-1:0]                 wr_en,
  input  logic [ST_COUNT-1:0][ADDR_WIDTH-1:0] wr_addr,
  input  logic [ST_COUNT-1:0][DATA_WIDTH-1:0] wr_data,
  // Error flags from the port units
  input  logic                                ld_tag_oob,
  input  logic                                st_tag_oob,
  input  logic                                st_deadlock,
  // Latched error
  output logic                                error_valid,
  output err_code_t                           error_code
);

  // --------------------------------------------------------------------
  // Memory array
  // --------------------------------------------------------------------
  logic [DATA_WIDTH-1:0] mem [0:MEM_DEPTH-1];

  // Reads see the contents as of the last edge
  genvar gi;
  generate
    for (gi = 0; gi < LD_COUNT; gi++) begin : g_rd
      assign rd_data[gi] = mem[rd_addr[gi]];
    end
  endgenerate

  // Writes applied in port order
  // Higher port wins on an address clash
  always_ff @(posedge clk) begin : mem_write
    for (int j = 0; j < ST_COUNT; j++) begin
      if (wr_en[j]) begin
        mem[wr_addr[j]] <= wr_data[j];
      end
    end
  end

  // --------------------------------------------------------------------
  // Error priority and latch
  // --------------------------------------------------------------------
  logic      err_detect;
  err_code_t err_code_next;

  always_comb begin : err_priority
    err_detect    = ld_tag_oob | st_tag_oob | st_deadlock;
    err_code_next = RT_MEMORY_NONE;
    if (ld_tag_oob || st_tag_oob) begin
      err_code_next = RT_MEMORY_TAG_OOB;
    end
    // Deadlock overrides a tag error
    if (st_deadlock) begin
      err_code_next = RT_MEMORY_STORE_DEADLOCK;
    end
  end

  // First error held until reset
  always_ff @(posedge clk or negedge rst_n) begin : error_latch
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= RT_MEMORY_NONE;
    end else if (!error_valid && err_detect) begin
      error_valid <= 1'b1;
      error_code  <= err_code_next;
    end
  end

endmodule

/* verilog/fabric_memory.sv */
// ----------------------------------------------------------------------
// Fabric scratchpad memory top level
// Load port unit and store pairing unit around a shared core
// ----------------------------------------------------------------------

module fabric_memory
  import fabric_mem_cfg_pkg::*, fabric_err_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  // Load address streams
  input  logic     [LD_COUNT-1:0] ld_addr_valid,
  output logic     [LD_COUNT-1:0] ld_addr_ready,
  input  payload_t [LD_COUNT-1:0] ld_addr,
  // Load data streams
  output logic     [LD_COUNT-1:0] ld_data_valid,
  input  logic     [LD_COUNT-1:0] ld_data_ready,
  output payload_t [LD_COUNT-1:0] ld_data,
  // Load-done stream
  output logic                    ld_done_valid,
  input  logic                    ld_done_ready,
  output payload_t                ld_done,
  // Store address streams
  input  logic     [ST_COUNT-1:0] st_addr_valid,
  output logic     [ST_COUNT-1:0] st_addr_ready,
  input  payload_t [ST_COUNT-1:0] st_addr,
  // Store data streams
  input  logic     [ST_COUNT-1:0] st_data_valid,
  output logic     [ST_COUNT-1:0] st_data_ready,
  input  payload_t [ST_COUNT-1:0] st_data,
  // Store-done stream
  output logic                    st_done_valid,
  input  logic                    st_done_ready,
  output payload_t                st_done,
  // Runtime error
  output logic                    error_valid,
  output err_code_t               error_code
);

  // Memory access wires
  logic [LD_COUNT-1:0][ADDR_WIDTH-1:0] rd_addr;
  logic [LD_COUNT-1:0][DATA_WIDTH-1:0] rd_data;
  logic [ST_COUNT-1:0]                 wr_en;
  logic [ST_COUNT-1:0][ADDR_WIDTH-1:0] wr_addr;
  logic [ST_COUNT-1:0][DATA_WIDTH-1:0] wr_data;
  // Error flags
  logic                                ld_tag_oob;
  logic                                st_tag_oob;
  logic                                st_deadlock;

  mem_load_ports u_load (
    .ld_addr_valid (ld_addr_valid),
    .ld_addr_ready (ld_addr_ready),
    .ld_addr       (ld_addr),
    .ld_data_valid (ld_data_valid),
    .ld_data_ready (ld_data_ready),
    .ld_data       (ld_data),
    .ld_done_valid (ld_done_valid),
    .ld_done_ready (ld_done_ready),
    .ld_done       (ld_done),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .ld_tag_oob    (ld_tag_oob)
  );

  mem_store_pairing u_store (
    .clk           (clk),
    .rst_n         (rst_n),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_addr       (st_addr),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .st_data       (st_data),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready),
    .st_done       (st_done),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .st_tag_oob    (st_tag_oob),
    .st_deadlock   (st_deadlock)
  );

  scratchpad_core u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .ld_tag_oob  (ld_tag_oob),
    .st_tag_oob  (st_tag_oob),
    .st_deadlock (st_deadlock),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

endmodule

/* testbench/fabric_memory_chk.sv */
// ----------------------------------------------------------------------
// Scratchpad protocol checks
// Handshake and error latch assertions bound to the top level
// ----------------------------------------------------------------------

module fabric_memory_chk
  import fabric_mem_cfg_pkg::*, fabric_err_pkg::*;
(
  input logic                clk,
  input logic                rst_n,
  input logic [LD_COUNT-1:0] ld_addr_valid,
  input logic [LD_COUNT-1:0] ld_addr_ready,
  input logic [ST_COUNT-1:0] st_addr_valid,
  input logic [ST_COUNT-1:0] st_addr_ready,
  input logic [ST_COUNT-1:0] st_data_valid,
  input logic [ST_COUNT-1:0] st_data_ready,
  input logic                error_valid,
  input err_code_t           error_code
);

  timeunit 1ns;
  timeprecision 1ps;

  // Ready only while its own valid is up
  a_ld_ready : assert property (@(posedge clk) disable iff (!rst_n)
    (ld_addr_ready & ~ld_addr_valid) == '0)
    else $error("load address ready without valid");

  a_st_ready : assert property (@(posedge clk) disable iff (!rst_n)
    ((st_addr_ready & ~st_addr_valid) == '0) && ((st_data_ready & ~st_data_valid) == '0))
    else $error("store ready without valid");

  // Address and data halves accepted together
  a_st_pair : assert property (@(posedge clk) disable iff (!rst_n)
    st_addr_ready == st_data_ready)
    else $error("store address and data ready differ");

  // Error latch is sticky
  a_err_sticky : assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(error_valid))
    else $error("error_valid fell outside reset");

  // A latched error always carries a code
  a_err_code : assert property (@(posedge clk) disable iff (!rst_n)
    error_valid |-> (error_code != RT_MEMORY_NONE))
    else $error("error_valid high with a zero error code");

endmodule

bind fabric_memory fabric_memory_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .ld_addr_valid (ld_addr_valid),
  .ld_addr_ready (ld_addr_ready),
  .st_addr_valid (st_addr_valid),
  .st_addr_ready (st_addr_ready),
  .st_data_valid (st_data_valid),
  .st_data_ready (st_data_ready),
  .error_valid   (error_valid),
  .error_code    (error_code)
);

/* testbench/tb_fabric_memory.sv */
// ----------------------------------------------------------------------
// Fabric scratchpad testbench
// Replays the cases file against a memory model and checks load data,
// done streams, back-pressure and the error latch
// ----------------------------------------------------------------------

module tb_fabric_memory
  import fabric_mem_cfg_pkg::*, fabric_err_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // ---------------------------------------------------------------------
  // DUT signals
  // ---------------------------------------------------------------------
  logic                    clk;
  logic                    rst_n;
  logic     [LD_COUNT-1:0] ld_addr_valid;
  logic     [LD_COUNT-1:0] ld_addr_ready;
  payload_t [LD_COUNT-1:0] ld_addr;
  logic     [LD_COUNT-1:0] ld_data_valid;
  logic     [LD_COUNT-1:0] ld_data_ready;
  payload_t [LD_COUNT-1:0] ld_data;
  logic                    ld_done_valid;
  logic                    ld_done_ready;
  payload_t                ld_done;
  logic     [ST_COUNT-1:0] st_addr_valid;
  logic     [ST_COUNT-1:0] st_addr_ready;
  payload_t [ST_COUNT-1:0] st_addr;
  logic     [ST_COUNT-1:0] st_data_valid;
  logic     [ST_COUNT-1:0] st_data_ready;
  payload_t [ST_COUNT-1:0] st_data;
  logic                    st_done_valid;
  logic                    st_done_ready;
  payload_t                st_done;
  logic                    error_valid;
  err_code_t               error_code;

  // Memory model, updated when a store is seen to fire
  logic [DATA_WIDTH-1:0] model [MEM_DEPTH];

  // Cases from the file, one entry per line
  string                 name_q [$];
  string                 op_q   [$];
  int                    port_q [$];
  int                    addr_q [$];
  logic [DATA_WIDTH-1:0] data_q [$];
  int                    tag_q  [$];
  payload_t              exp_q  [$];
  logic                  cases_loaded = 1'b0;
  logic [31:0]           rng_state    = 32'h541a_65e5;

  fabric_memory u_dut (.*);

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Tag field directly above the data field
  function automatic payload_t make_payload(input int tag, input logic [DATA_WIDTH-1:0] data);
    return {tag[TAG_WIDTH-1:0], data};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_payload(input string name, input payload_t exp, input payload_t act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_error(input string name, input err_code_t exp, input err_code_t act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: expected code %0d, actual code %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // All streams quiet, every ready up
  task automatic idle_inputs();
    ld_addr_valid = '0;
    ld_addr       = '0;
    ld_data_ready = '1;
    ld_done_ready = 1'b1;
    st_addr_valid = '0;
    st_addr       = '0;
    st_data_valid = '0;
    st_data       = '0;
    st_done_ready = 1'b1;
  endtask

  // Data half carries the other in-range tag
  // so the done tag shows which half it came from
  task automatic drive_store(input int port, input int addr, input logic [DATA_WIDTH-1:0] data,
                             input int tag, input logic valid);
    st_addr_valid[port] = valid;
    st_data_valid[port] = valid;
    st_addr[port]       = make_payload(tag, DATA_WIDTH'(addr));
    st_data[port]       = make_payload(tag ^ 1, data);
  endtask

  task automatic drive_load(input int port, input int addr, input int tag, input logic valid);
    ld_addr_valid[port] = valid;
    ld_addr[port]       = make_payload(tag, DATA_WIDTH'(addr));
  endtask

  // Reset, then the latch must read clear before any stimulus
  task automatic apply_reset(input string name);
    rst_n = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag({name, " error_valid"}, 1'b0, error_valid);
    check_error({name, " error_code"}, RT_MEMORY_NONE, error_code);
  endtask

  // ---------------------------------------------------------------------
  // Case operations
  // Outputs sampled on the falling edge, after the firing edge
  // ---------------------------------------------------------------------
  task automatic do_store(input string name, input int port, input int addr,
                          input logic [DATA_WIDTH-1:0] data, input int tag, input payload_t done);
    drive_store(port, addr, data, tag, 1'b1);
    do begin
      @(negedge clk);
    end while (!st_addr_ready[port]);
    check_flag({name, " st_data_ready"}, 1'b1, st_data_ready[port]);
    check_flag({name, " st_done_valid"}, 1'b1, st_done_valid);
    check_payload({name, " st_done"}, done, st_done);
    model[addr] = data;
    drive_store(port, 0, '0, 0, 1'b0);
  endtask

  task automatic do_load(input string name, input int port, input int addr, input int tag,
                         input payload_t exp);
    drive_load(port, addr, tag, 1'b1);
    do begin
      @(negedge clk);
    end while (!ld_addr_ready[port]);
    check_payload(name, exp, ld_data[port]);
    check_payload({name, " model"}, make_payload(tag, model[addr]), ld_data[port]);
    check_flag({name, " ld_done_valid"}, 1'b1, ld_done_valid);
    check_payload({name, " ld_done"}, make_payload(tag, '0), ld_done);
    drive_load(port, 0, 0, 1'b0);
  endtask

  // Same address from both store ports on one edge
  task automatic do_dual(input string name, input int port, input int addr,
                         input logic [DATA_WIDTH-1:0] data, input int tag, input payload_t exp);
    logic [DATA_WIDTH-1:0] first;
    rng_state = xorshift32(rng_state);
    first     = rng_state[DATA_WIDTH-1:0];
    drive_store(0, addr, first, 0, 1'b1);
    drive_store(1, addr, data, tag, 1'b1);
    do begin
      @(negedge clk);
    end while (st_addr_ready != '1);
    check_payload({name, " st_done"}, make_payload(tag, '0), st_done);
    // Higher port wins the clash
    model[addr] = data;
    drive_store(0, 0, '0, 0, 1'b0);
    drive_store(1, 0, '0, 0, 1'b0);
    do_load(name, port, addr, tag, exp);
  endtask

  // Done readies held low for a random number of cycles
  task automatic do_stall(input string name, input int port, input int addr,
                          input logic [DATA_WIDTH-1:0] data, input int tag, input payload_t exp);
    int n;
    rng_state = xorshift32(rng_state);
    n = 1 + int'(rng_state % 32'd6);
    ld_done_ready = 1'b0;
    st_done_ready = 1'b0;
    drive_store(port, addr, data, tag, 1'b1);
    drive_load(port, addr, tag, 1'b1);
    repeat (n) begin
      @(negedge clk);
      check_flag({name, " st ready"}, 1'b0, st_addr_ready[port]);
      check_flag({name, " ld ready"}, 1'b0, ld_addr_ready[port]);
      check_flag({name, " ld valid"}, 1'b1, ld_data_valid[port]);
      // Store held back, old word still visible
      check_payload({name, " old"}, make_payload(tag, model[addr]), ld_data[port]);
    end
    ld_done_ready = 1'b1;
    st_done_ready = 1'b1;
    do begin
      @(negedge clk);
    end while (!(st_addr_ready[port] && ld_addr_ready[port]));
    model[addr] = data;
    drive_store(port, 0, '0, 0, 1'b0);
    drive_load(port, 0, 0, 1'b0);
    do_load(name, port, addr, tag, exp);
  endtask

  // Bad tag on a load, or on a lone store data half
  task automatic do_tag_error(input string name, input logic is_load, input int port,
                              input int addr, input logic [DATA_WIDTH-1:0] data,
                              input int tag, input err_code_t exp);
    apply_reset(name);
    if (is_load) begin
      drive_load(port, addr, tag, 1'b1);
    end else begin
      st_data_valid[port] = 1'b1;
      st_data[port]       = make_payload(tag, data);
    end
    // Latched on the next edge
    @(negedge clk);
    check_flag({name, " error_valid"}, 1'b1, error_valid);
    check_error(name, exp, error_code);
    idle_inputs();
    repeat (3) @(negedge clk);
    check_flag({name, " held"}, 1'b1, error_valid);
    check_error({name, " held"}, exp, error_code);
  endtask

  // Store address half alone until the counter saturates
  task automatic do_deadlock(input string name, input int port, input int addr, input int tag,
                             input err_code_t exp);
    int waited;
    apply_reset(name);
    st_addr_valid[port] = 1'b1;
    st_addr[port]       = make_payload(tag, DATA_WIDTH'(addr));
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!error_valid && (waited < DEADLOCK_TIMEOUT + 2));
    if (!error_valid) begin
      fail_run($sformatf("%s: no deadlock error after %0d cycles", name, waited));
    end else if (waited < DEADLOCK_TIMEOUT) begin
      fail_run($sformatf("%s: deadlock error raised after only %0d cycles", name, waited));
    end else begin
      check_error(name, exp, error_code);
    end
    idle_inputs();
  endtask

  // ---------------------------------------------------------------------
  // Watchdog, sized from the case count
  // ---------------------------------------------------------------------
  initial begin : watchdog
    wait (cases_loaded);
    repeat (op_q.size() * 40 + DEADLOCK_TIMEOUT * 4) @(posedge clk);
    fail_run("Timeout: the cases did not complete in the allowed number of cycles");
  end

  // ---------------------------------------------------------------------
  // Case reader and sequencer
  // ---------------------------------------------------------------------
  initial begin : main
    int                    fd;
    int                    cnt;
    int                    port;
    int                    addr;
    int                    tag;
    logic [DATA_WIDTH-1:0] data;
    payload_t              exp;
    logic [8*256-1:0]      line;
    logic [8*16-1:0]       name_v;
    logic [8*16-1:0]       op_v;
    idle_inputs();
    rst_n = 1'b0;
    fd = $fopen("testbench/mem_cases.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the cases file testbench/mem_cases.txt");
    end
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0) begin
        cnt = $sscanf(line, "%s %s %d %h %h %d %h", name_v, op_v, port, addr, data, tag, exp);
        // Comment and blank lines never fill all seven fields
        if (cnt == 7) begin
          name_q.push_back(string'(name_v));
          op_q.push_back(string'(op_v));
          port_q.push_back(port);
          addr_q.push_back(addr);
          data_q.push_back(data);
          tag_q.push_back(tag);
          exp_q.push_back(exp);
        end
      end
    end
    $fclose(fd);
    cases_loaded = 1'b1;

    apply_reset("reset");
    foreach (op_q[i]) begin
      if (op_q[i] == "store") begin
        do_store(name_q[i], port_q[i], addr_q[i], data_q[i], tag_q[i], exp_q[i]);
      end else if (op_q[i] == "load") begin
        do_load(name_q[i], port_q[i], addr_q[i], tag_q[i], exp_q[i]);
      end else if (op_q[i] == "stl") begin
        do_store(name_q[i], port_q[i], addr_q[i], data_q[i], tag_q[i],
                 make_payload(tag_q[i], '0));
        do_load(name_q[i], port_q[i], addr_q[i], tag_q[i], exp_q[i]);
      end else if (op_q[i] == "dual") begin
        do_dual(name_q[i], port_q[i], addr_q[i], data_q[i], tag_q[i], exp_q[i]);
      end else if (op_q[i] == "stall") begin
        do_stall(name_q[i], port_q[i], addr_q[i], data_q[i], tag_q[i], exp_q[i]);
      end else if (op_q[i] == "ld_tag" || op_q[i] == "st_tag") begin
        do_tag_error(name_q[i], op_q[i] == "ld_tag", port_q[i], addr_q[i], data_q[i],
                     tag_q[i], err_code_t'(exp_q[i]));
      end else if (op_q[i] == "deadlock") begin
        do_deadlock(name_q[i], port_q[i], addr_q[i], tag_q[i], err_code_t'(exp_q[i]));
      end else begin
        fail_run($sformatf("Unknown operation %s in case %s", op_q[i], name_q[i]));
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* fabric_memory.f */
verilog/fabric_mem_cfg_pkg.sv
verilog/fabric_err_pkg.sv
verilog/mem_load_ports.sv
verilog/mem_store_pairing.sv
verilog/scratchpad_core.sv
verilog/fabric_memory.sv
testbench/fabric_memory_chk.sv
testbench/tb_fabric_memory.sv

/* Makefile */
# Verilator simulation of the fabric scratchpad memory

VERILATOR ?= verilator
TOP       ?= tb_fabric_memory
FILELIST  ?= fabric_memory.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
	  echo "Simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/mem_cases.txt */
# name op port addr data tag expected
# port and tag in decimal; addr, data and expected in hex
st_p0_a3   store    0 3 1234 1 10000
st_p1_a5   store    1 5 abcd 0 00000
ld_p0_a3   load     0 3 0000 0 01234
ld_p1_a3   load     1 3 0000 1 11234
ld_p0_a5   load     0 5 0000 1 1abcd
ld_p1_a5   load     1 5 0000 0 0abcd
stl_p0_a9  stl      0 9 5a5a 1 15a5a
stl_p1_af  stl      1 f c3c3 0 0c3c3
dual_a7    dual     1 7 7777 1 17777
stall_p0   stall    0 3 0f0f 0 00f0f
stall_p1   stall    1 5 f00d 1 1f00d
ld_tag_p1  ld_tag   1 2 0000 2 00001
st_tag_p0  st_tag   0 4 beef 3 00001
dl_p1      deadlock 1 6 0000 0 00002
